// ==== flist.f ====
+incdir+.
mem_ctrl_pkg.sv
async_fifo.sv
bmem_sequencer.sv
read_beat_assembler.sv
fpga_mem_controller.sv
tb_clock_gen.sv
tb_fpga_mem_controller.sv

// ==== Makefile ====
# Verilator flow for the memory controller

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_fpga_mem_controller
RTL_TOP    ?= fpga_mem_controller
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall --timing

.PHONY: all lint sim clean

all: sim

# lint the synthesizable top only
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

# build and run, exit status is the pass or fail result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_fpga_mem_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defines.svh"

module tb_fpga_mem_controller;

    localparam logic [31:0] SEED       = 32'h44b2_5f56;
    localparam int          NUM_TXNS   = 60;
    localparam int          WAIT_LIMIT = 2000;
    // sixteen lines only, so reads often land on written lines
    localparam logic [31:0] ADDR_BASE  = 32'h0004_0000;
    localparam logic [31:0] ACK_WORD   = 32'h0000_0ac4;

    logic                   clk;
    logic                   fpga_clk;
    logic                   rst;
    logic [`MEM_ADDR_W-1:0] bmem_addr;
    logic                   bmem_read;
    logic                   bmem_write;
    logic [`MEM_LINE_W-1:0] bmem_wdata;
    logic                   bmem_ready;
    logic [`MEM_ADDR_W-1:0] bmem_raddr;
    logic [`MEM_LINE_W-1:0] bmem_rdata;
    logic                   bmem_rvalid;
    logic                   bmem_whalf;
    // memory side inputs, owned by the memory model
    logic                   mem_req_pop = 1'b0;
    logic                   mem_resp_push = 1'b0;
    logic [`MEM_BUS_W-1:0]  mem_resp_data = '0;
    logic                   mem_req_empty;
    logic                   mem_resp_full;
    logic [`MEM_BUS_W-1:0]  mem_bus;
    logic                   mem_addr_on;
    logic                   mem_data_on;
    logic                   mem_read_en;
    logic                   mem_write_en;

    // memory model state
    logic [31:0] model_mem [logic [31:0]];
    logic [31:0] resp_q [$];
    logic [31:0] model_base = '0;
    bit          model_in_write = 1'b0;
    int          model_word_idx = 0;

    // current cache transaction and the lines written so far
    logic [31:0] cur_addr = '0;
    bit          cur_is_write = 1'b0;
    logic [63:0] cur_line [4];
    logic [63:0] written_beats [logic [31:0]];
    logic [31:0] rng_state;

    tb_clock_gen #(.period(8))  cache_clk_gen (.clk(clk));
    tb_clock_gen #(.period(20)) fpga_clk_gen  (.clk(fpga_clk));

    fpga_mem_controller uut (
        .clk           (clk),
        .fpga_clk      (fpga_clk),
        .rst           (rst),
        .bmem_addr     (bmem_addr),
        .bmem_read     (bmem_read),
        .bmem_write    (bmem_write),
        .bmem_wdata    (bmem_wdata),
        .bmem_ready    (bmem_ready),
        .bmem_raddr    (bmem_raddr),
        .bmem_rdata    (bmem_rdata),
        .bmem_rvalid   (bmem_rvalid),
        .bmem_whalf    (bmem_whalf),
        .mem_req_pop   (mem_req_pop),
        .mem_resp_push (mem_resp_push),
        .mem_resp_data (mem_resp_data),
        .mem_req_empty (mem_req_empty),
        .mem_resp_full (mem_resp_full),
        .mem_bus       (mem_bus),
        .mem_addr_on   (mem_addr_on),
        .mem_data_on   (mem_data_on),
        .mem_read_en   (mem_read_en),
        .mem_write_en  (mem_write_en)
    );

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "first mismatch reached");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "wait limit exceeded");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // contents of a never written word, from the whole word address
    function automatic logic [31:0] fill_word(input logic [31:0] waddr);
        return xorshift32(waddr ^ 32'h9e37_79b9);
    endfunction

    function automatic logic [31:0] stored_word(input logic [31:0] waddr);
        if (model_mem.exists(waddr)) begin
            return model_mem[waddr];
        end else begin
            return fill_word(waddr);
        end
    endfunction

    // beat i of a line, high word is the odd one
    function automatic logic [63:0] expected_beat(input logic [31:0] addr, input int i);
        logic [31:0] key;
        logic [31:0] waddr;
        key   = addr + 32'(8 * i);
        waddr = (addr >> 2) + 32'(2 * i);
        if (written_beats.exists(key)) begin
            return written_beats[key];
        end else begin
            return {fill_word(waddr + 32'd1), fill_word(waddr)};
        end
    endfunction

    // one word from the request fifo head
    task automatic take_request_word();
        mem_ctrl_pkg::mem_req_t head;
        logic [31:0]            want;
        head = {mem_write_en, mem_read_en, mem_data_on, mem_addr_on, mem_bus};
        if (head.addr_on) begin
            assert (!model_in_write)
                else report_mismatch("address word inside a write burst");
            assert (!head.data_on && head.bus == cur_addr)
                else report_mismatch($sformatf("address word bus %h data_on %b, expected %h",
                                               head.bus, head.data_on, cur_addr));
            assert (head.write_en == cur_is_write && head.read_en == !cur_is_write)
                else report_mismatch($sformatf("address word write_en %b read_en %b",
                                               head.write_en, head.read_en));
            model_base     = head.bus >> 2;
            model_word_idx = 0;
            if (head.write_en) begin
                model_in_write = 1'b1;
            end else begin
                // whole burst queued at once
                for (int k = 0; k < `MEM_BURST_WORDS; k++) begin
                    resp_q.push_back(stored_word(model_base + 32'(k)));
                end
            end
        end else begin
            assert (model_in_write && head.data_on && head.write_en && !head.read_en)
                else report_mismatch($sformatf("stray data word, flags %b%b%b",
                                               head.write_en, head.read_en, head.data_on));
            // even words low half, odd words high half
            if (model_word_idx % 2 == 1) begin
                want = cur_line[model_word_idx / 2][63:32];
            end else begin
                want = cur_line[model_word_idx / 2][31:0];
            end
            assert (head.bus == want)
                else report_mismatch($sformatf("data word %0d is %h, expected %h",
                                               model_word_idx, head.bus, want));
            model_mem[model_base + 32'(model_word_idx)] = head.bus;
            model_word_idx++;
            if (model_word_idx == `MEM_BURST_WORDS) begin
                model_in_write = 1'b0;
                resp_q.push_back(ACK_WORD);
            end
        end
    endtask

    // memory model on the falling fpga_clk edge
    always @(negedge fpga_clk) begin
        mem_req_pop   = 1'b0;
        mem_resp_push = 1'b0;
        if (resp_q.size() > 0 && !mem_resp_full) begin
            mem_resp_data = resp_q.pop_front();
            mem_resp_push = 1'b1;
        end
        if (!mem_req_empty) begin
            mem_req_pop = 1'b1;
            take_request_word();
        end
    end

    task automatic wait_for_ready(input string what);
        int cycles;
        cycles = 0;
        while (!bmem_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout(what);
            end
        end
    endtask

    task automatic read_line(input logic [31:0] addr);
        logic [63:0] expected;
        int          beats;
        int          cycles;
        wait_for_ready("bmem_ready before a read");
        cur_addr     = addr;
        cur_is_write = 1'b0;
        bmem_addr    = addr;
        bmem_read    = 1'b1;
        @(negedge clk);
        // accepted on the edge just passed
        bmem_read = 1'b0;
        beats     = 0;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (bmem_rvalid) begin
                assert (beats < 4) else report_mismatch("more than four read beats");
                expected = expected_beat(addr, beats);
                assert (bmem_rdata == expected)
                    else report_mismatch($sformatf("read %h beat %0d is %h, expected %h",
                                                   addr, beats, bmem_rdata, expected));
                assert (bmem_raddr == addr)
                    else report_mismatch($sformatf("bmem_raddr %h, expected %h",
                                                   bmem_raddr, addr));
                beats++;
            end
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("the read burst to finish");
            end
        end while (!bmem_ready);
        assert (beats == 4)
            else report_mismatch($sformatf("read gave %0d beats, expected 4", beats));
    endtask

    task automatic write_line(input logic [31:0] addr);
        logic [31:0] hi;
        logic [31:0] lo;
        logic        whalf_prev;
        logic        acked;
        int          beat;
        int          halves;
        int          cycles;
        for (int i = 0; i < 4; i++) begin
            hi          = next_rand();
            lo          = next_rand();
            cur_line[i] = {hi, lo};
        end
        wait_for_ready("bmem_ready before a write");
        cur_addr     = addr;
        cur_is_write = 1'b1;
        bmem_addr    = addr;
        bmem_wdata   = cur_line[0];
        bmem_write   = 1'b1;
        beat         = 0;
        halves       = 0;
        cycles       = 0;
        whalf_prev   = 1'b0;
        acked        = 1'b0;
        while (!acked) begin
            @(negedge clk);
            cycles++;
            // high half went out last cycle, next beat
            if (whalf_prev && beat < 3) begin
                beat++;
                bmem_wdata = cur_line[beat];
            end
            whalf_prev = bmem_whalf;
            if (bmem_whalf) begin
                halves++;
            end
            assert (!bmem_rvalid) else report_mismatch("bmem_rvalid during a write");
            acked = bmem_ready;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("the write acknowledgement");
            end
        end
        assert (halves == 4)
            else report_mismatch($sformatf("bmem_whalf pulsed %0d times, expected 4", halves));
        assert (model_word_idx == `MEM_BURST_WORDS)
            else report_mismatch($sformatf("ack after only %0d data words", model_word_idx));
        @(negedge clk);
        // one-cycle ack pulse while bmem_write is still high
        assert (!bmem_ready) else report_mismatch("bmem_ready stuck high after the ack");
        bmem_write = 1'b0;
        for (int i = 0; i < 4; i++) begin
            written_beats[addr + 32'(8 * i)] = cur_line[i];
        end
        wait_for_ready("bmem_ready after bmem_write dropped");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        rng_state  = SEED;
        rst        = 1'b1;
        bmem_addr  = '0;
        bmem_read  = 1'b0;
        bmem_write = 1'b0;
        bmem_wdata = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (bmem_ready && !bmem_rvalid && mem_req_empty && !mem_resp_full)
            else report_mismatch($sformatf("after reset ready %b rvalid %b empty %b full %b",
                                           bmem_ready, bmem_rvalid, mem_req_empty,
                                           mem_resp_full));
        for (int n = 0; n < NUM_TXNS; n++) begin
            r    = next_rand();
            addr = ADDR_BASE + {23'd0, r[8:5], 5'd0};
            if (r[0]) begin
                write_line(addr);
            end else begin
                read_line(addr);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    // full period in ns
    parameter int period = 8
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== fpga_mem_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defines.svh"

module fpga_mem_controller (
    input  wire logic                   clk,
    input  wire logic                   fpga_clk,
    input  wire logic                   rst,
    // cache side
    input  wire logic [`MEM_ADDR_W-1:0] bmem_addr,
    input  wire logic                   bmem_read,
    input  wire logic                   bmem_write,
    input  wire logic [`MEM_LINE_W-1:0] bmem_wdata,
    output logic                        bmem_ready,
    output logic [`MEM_ADDR_W-1:0]      bmem_raddr,
    output logic [`MEM_LINE_W-1:0]      bmem_rdata,
    output logic                        bmem_rvalid,
    output logic                        bmem_whalf,
    // memory side
    input  wire logic                   mem_req_pop,
    input  wire logic                   mem_resp_push,
    input  wire logic [`MEM_BUS_W-1:0]  mem_resp_data,
    output logic                        mem_req_empty,
    output logic                        mem_resp_full,
    output logic [`MEM_BUS_W-1:0]       mem_bus,
    output logic                        mem_addr_on,
    output logic                        mem_data_on,
    output logic                        mem_read_en,
    output logic                        mem_write_en
);

    logic                    req_push;
    logic                    req_full;
    mem_ctrl_pkg::mem_req_t  req_word;
    mem_ctrl_pkg::mem_req_t  req_head;
    logic                    resp_pop;
    logic                    rd_pop;
    logic                    resp_empty;
    mem_ctrl_pkg::mem_resp_t resp_head;

    // clk to fpga_clk, request words
    async_fifo #(
        .payload_t (mem_ctrl_pkg::mem_req_t)
    ) req_fifo (
        .w_clk    (clk),
        .r_clk    (fpga_clk),
        .rst      (rst),
        .w_en     (req_push),
        .r_en     (mem_req_pop),
        .data_in  (req_word),
        .full     (req_full),
        .empty    (mem_req_empty),
        .data_out (req_head)
    );

    // fpga_clk to clk, read data and write acks
    async_fifo #(
        .payload_t (mem_ctrl_pkg::mem_resp_t)
    ) resp_fifo (
        .w_clk    (fpga_clk),
        .r_clk    (clk),
        .rst      (rst),
        .w_en     (mem_resp_push),
        .r_en     (resp_pop),
        .data_in  (mem_resp_data),
        .full     (mem_resp_full),
        .empty    (resp_empty),
        .data_out (resp_head)
    );

    bmem_sequencer sequencer (
        .clk        (clk),
        .rst        (rst),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_addr  (bmem_addr),
        .bmem_wdata (bmem_wdata),
        .req_full   (req_full),
        .resp_empty (resp_empty),
        .bmem_ready (bmem_ready),
        .bmem_whalf (bmem_whalf),
        .bmem_raddr (bmem_raddr),
        .req_push   (req_push),
        .req_word   (req_word),
        .resp_pop   (resp_pop),
        .rd_pop     (rd_pop)
    );

    // only read pops reach the beat register
    read_beat_assembler assembler (
        .clk         (clk),
        .rst         (rst),
        .word_pop    (rd_pop),
        .word        (resp_head),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

    // fifo head fields onto the memory ports
    assign mem_bus      = req_head.bus;
    assign mem_addr_on  = req_head.addr_on;
    assign mem_data_on  = req_head.data_on;
    assign mem_read_en  = req_head.read_en;
    assign mem_write_en = req_head.write_en;

endmodule

`default_nettype wire

// ==== read_beat_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defines.svh"

module read_beat_assembler (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   word_pop,
    input  wire mem_ctrl_pkg::mem_resp_t word,
    output logic [`MEM_LINE_W-1:0]      bmem_rdata,
    output logic                        bmem_rvalid
);

    // low half next when clear
    logic upper_half;

    always_ff @(posedge clk) begin
        if (rst) begin
            upper_half  <= 1'b0;
            bmem_rvalid <= 1'b0;
        end else begin
            if (word_pop) begin
                upper_half <= !upper_half;
            end
            // beat complete once the high half lands
            bmem_rvalid <= word_pop && upper_half;
        end
    end

    // beat data, only moves on a pop
    always_ff @(posedge clk) begin
        if (word_pop) begin
            if (upper_half) begin
                bmem_rdata[`MEM_LINE_W-1:`MEM_BUS_W] <= word;
            end else begin
                bmem_rdata[`MEM_BUS_W-1:0] <= word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bmem_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defines.svh"

module bmem_sequencer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   bmem_read,
    input  wire logic                   bmem_write,
    input  wire logic [`MEM_ADDR_W-1:0] bmem_addr,
    input  wire logic [`MEM_LINE_W-1:0] bmem_wdata,
    input  wire logic                   req_full,
    input  wire logic                   resp_empty,
    output logic                        bmem_ready,
    output logic                        bmem_whalf,
    output logic [`MEM_ADDR_W-1:0]      bmem_raddr,
    output logic                        req_push,
    output mem_ctrl_pkg::mem_req_t      req_word,
    output logic                        resp_pop,
    output logic                        rd_pop
);

    localparam int CNT_W = $clog2(`MEM_BURST_WORDS);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`MEM_BURST_WORDS - 1);

    mem_ctrl_pkg::ctrl_state_t state;
    mem_ctrl_pkg::ctrl_state_t state_next;

    // burst word index, reused to time the drain
    logic [CNT_W-1:0]       word_cnt;
    logic [CNT_W-1:0]       cnt_next;
    logic                   is_write;
    logic                   addr_load;
    logic [`MEM_ADDR_W-1:0] latched_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= mem_ctrl_pkg::IDLE;
            word_cnt <= '0;
            is_write <= 1'b0;
        end else begin
            state    <= state_next;
            word_cnt <= cnt_next;
            // read wins when both are requested
            if (addr_load) begin
                is_write <= !bmem_read;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_load) begin
            latched_addr <= bmem_addr;
        end
    end

    assign bmem_raddr = latched_addr;

    always_comb begin
        state_next = state;
        cnt_next   = word_cnt;
        addr_load  = 1'b0;
        bmem_ready = 1'b0;
        bmem_whalf = 1'b0;
        req_push   = 1'b0;
        req_word   = '0;
        resp_pop   = 1'b0;
        rd_pop     = 1'b0;
        unique case (state)
            mem_ctrl_pkg::IDLE: begin
                bmem_ready = 1'b1;
                if (bmem_read || bmem_write) begin
                    addr_load  = 1'b1;
                    cnt_next   = '0;
                    state_next = mem_ctrl_pkg::SEND_ADDR;
                end
            end
            mem_ctrl_pkg::SEND_ADDR: begin
                // address word, op flag from the accept cycle
                req_word.write_en = is_write;
                req_word.read_en  = !is_write;
                req_word.addr_on  = 1'b1;
                req_word.bus      = latched_addr;
                if (!req_full) begin
                    req_push = 1'b1;
                    if (is_write) begin
                        state_next = mem_ctrl_pkg::WRITE_DATA;
                    end else begin
                        state_next = mem_ctrl_pkg::READ_DATA;
                    end
                end
            end
            mem_ctrl_pkg::WRITE_DATA: begin
                req_word.write_en = 1'b1;
                req_word.data_on  = 1'b1;
                // even words low half, odd words high half
                if (word_cnt[0]) begin
                    req_word.bus = bmem_wdata[`MEM_LINE_W-1:`MEM_BUS_W];
                end else begin
                    req_word.bus = bmem_wdata[`MEM_BUS_W-1:0];
                end
                if (!req_full) begin
                    req_push = 1'b1;
                    // high half gone, cache moves to its next beat
                    bmem_whalf = word_cnt[0];
                    cnt_next   = word_cnt + 1'b1;
                    if (word_cnt == LAST_WORD) begin
                        state_next = mem_ctrl_pkg::WRITE_RESP;
                    end
                end
            end
            mem_ctrl_pkg::WRITE_RESP: begin
                // any response word counts as the ack
                if (!resp_empty) begin
                    resp_pop   = 1'b1;
                    bmem_ready = 1'b1;
                    state_next = mem_ctrl_pkg::WRITE_RELEASE;
                end
            end
            mem_ctrl_pkg::WRITE_RELEASE: begin
                if (!bmem_write) begin
                    state_next = mem_ctrl_pkg::IDLE;
                end
            end
            mem_ctrl_pkg::READ_DATA: begin
                if (!resp_empty) begin
                    resp_pop = 1'b1;
                    rd_pop   = 1'b1;
                    cnt_next = word_cnt + 1'b1;
                    if (word_cnt == LAST_WORD) begin
                        state_next = mem_ctrl_pkg::READ_DRAIN;
                    end
                end
            end
            mem_ctrl_pkg::READ_DRAIN: begin
                // counter wrapped to 0 on the last pop
                cnt_next = word_cnt + 1'b1;
                if (word_cnt == CNT_W'(1)) begin
                    cnt_next   = '0;
                    state_next = mem_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = mem_ctrl_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== async_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_defines.svh"

module async_fifo #(
    parameter type payload_t = logic [`MEM_BUS_W-1:0],
    parameter int  addr_bits = `MEM_FIFO_AW
) (
    input  wire logic     w_clk,
    input  wire logic     r_clk,
    input  wire logic     rst,
    input  wire logic     w_en,
    input  wire logic     r_en,
    input  wire payload_t data_in,
    output logic          full,
    output logic          empty,
    output payload_t      data_out
);

    localparam int DEPTH = 1 << addr_bits;

    // storage, no reset
    payload_t mem [DEPTH];

    // one extra pointer bit tells wrap from equal
    logic [addr_bits:0] w_bin;
    logic [addr_bits:0] w_gray;
    logic [addr_bits:0] r_bin;
    logic [addr_bits:0] r_gray;

    // read pointer seen in write domain
    logic [addr_bits:0] r_gray_s1;
    logic [addr_bits:0] r_gray_s2;
    // write pointer seen in read domain
    logic [addr_bits:0] w_gray_s1;
    logic [addr_bits:0] w_gray_s2;

    logic               push;
    logic               pop;
    logic [addr_bits:0] w_bin_next;
    logic [addr_bits:0] r_bin_next;

    // full and empty block the stray strobe
    assign push = w_en && !full;
    assign pop  = r_en && !empty;

    assign w_bin_next = w_bin + 1'b1;
    assign r_bin_next = r_bin + 1'b1;

    // write side
    always_ff @(posedge w_clk) begin
        if (rst) begin
            w_bin  <= '0;
            w_gray <= '0;
        end else if (push) begin
            w_bin  <= w_bin_next;
            w_gray <= w_bin_next ^ (w_bin_next >> 1);
        end
    end

    always_ff @(posedge w_clk) begin
        if (push) begin
            mem[w_bin[addr_bits-1:0]] <= data_in;
        end
    end

    // two-flop sync of the read pointer
    always_ff @(posedge w_clk) begin
        if (rst) begin
            r_gray_s1 <= '0;
            r_gray_s2 <= '0;
        end else begin
            r_gray_s1 <= r_gray;
            r_gray_s2 <= r_gray_s1;
        end
    end

    // full when the top two gray bits differ and the rest match
    assign full = (w_gray == {~r_gray_s2[addr_bits -: 2], r_gray_s2[addr_bits-2:0]});

    // read side
    always_ff @(posedge r_clk) begin
        if (rst) begin
            r_bin  <= '0;
            r_gray <= '0;
        end else if (pop) begin
            r_bin  <= r_bin_next;
            r_gray <= r_bin_next ^ (r_bin_next >> 1);
        end
    end

    // two-flop sync of the write pointer
    always_ff @(posedge r_clk) begin
        if (rst) begin
            w_gray_s1 <= '0;
            w_gray_s2 <= '0;
        end else begin
            w_gray_s1 <= w_gray;
            w_gray_s2 <= w_gray_s1;
        end
    end

    assign empty = (r_gray == w_gray_s2);

    // head word, valid while not empty
    assign data_out = mem[r_bin[addr_bits-1:0]];

endmodule

`default_nettype wire

// ==== mem_ctrl_pkg.sv ====
`default_nettype none

`include "mem_ctrl_defines.svh"

package mem_ctrl_pkg;

    // request word toward the memory side
    // top bits are the flags, low bits the address or data
    typedef struct packed {
        logic                  write_en;
        logic                  read_en;
        logic                  data_on;
        logic                  addr_on;
        logic [`MEM_BUS_W-1:0] bus;
    } mem_req_t;

    // response word toward the cache side
    typedef logic [`MEM_BUS_W-1:0] mem_resp_t;

    // cache-side controller states
    typedef enum logic [2:0] {
        IDLE,
        SEND_ADDR,
        READ_DATA,
        // two fixed cycles for the last beat to leave the assembler
        READ_DRAIN,
        WRITE_DATA,
        WRITE_RESP,
        // wait for the cache to drop bmem_write
        WRITE_RELEASE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== mem_ctrl_defines.svh ====
`ifndef MEM_CTRL_DEFINES_SVH
`define MEM_CTRL_DEFINES_SVH

// cache address width
`define MEM_ADDR_W 32

// one word on the memory-side bus
`define MEM_BUS_W 32

// cache beat, two bus words
`define MEM_LINE_W 64

// bus words per cache line burst
`define MEM_BURST_WORDS 8

// fifo pointer address bits
// depth 8, holds one full burst
`define MEM_FIFO_AW 3

`endif
